/* src/flash_pkg.sv */
// ----------------------------------------------------------
// shared types, opcodes and geometry for the SPI flash controller
// referenced by scoped names from every design file
// ----------------------------------------------------------
package flash_pkg;

    // ----------------------------------------------------------
    // width types
    // ----------------------------------------------------------
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  opcode_t;
    typedef logic [23:0] flash_addr_t;
    typedef logic [31:0] len_t;
    // one data phase, up to a full page
    typedef logic [8:0]  xfer_len_t;

    typedef enum logic [1:0] {
        job_erase,
        job_program,
        job_read
    } job_t;

    typedef enum logic [2:0] {
        st_idle,
        st_poll_ready,
        st_wren,
        st_wel_check,
        st_erase,
        st_program,
        st_read,
        st_done
    } seq_state_t;

    // ----------------------------------------------------------
    // flash commands and geometry
    // ----------------------------------------------------------
    localparam opcode_t op_rdsr         = 8'h05;
    localparam opcode_t op_wren         = 8'h06;
    localparam opcode_t op_sector_erase = 8'hD7;
    localparam opcode_t op_page_program = 8'h02;
    localparam opcode_t op_read         = 8'h03;

    localparam len_t sector_bytes = 32'd4096;
    localparam len_t page_bytes   = 32'd256;

    // status register bits
    localparam int sr_wip_bit = 0;
    localparam int sr_wel_bit = 1;

endpackage

/* src/flash_job_if.sv */
// ----------------------------------------------------------
// one accepted host job, from the command port to the sequencer
// ----------------------------------------------------------
interface flash_job_if;

    logic                 start;
    flash_pkg::job_t      kind;
    flash_pkg::len_t      bytes;
    logic                 done;

    modport cmd_port (
        output start, kind, bytes,
        input  done
    );

    modport seq (
        input  start, kind, bytes,
        output done
    );

endinterface

/* src/spi_cmd_if.sv */
// ----------------------------------------------------------
// one SPI transaction request and its byte stream
// sequencer side issues, engine side frames it on the pins
// ----------------------------------------------------------
interface spi_cmd_if;

    logic                   start;
    flash_pkg::opcode_t     opcode;
    flash_pkg::flash_addr_t addr;
    logic                   has_addr;
    flash_pkg::xfer_len_t   wr_len;
    flash_pkg::xfer_len_t   rd_len;
    logic                   wr_pop;
    logic                   rd_valid;
    flash_pkg::byte_t       rd_byte;
    logic                   done;

    modport seq (
        output start, opcode, addr, has_addr, wr_len, rd_len,
        input  rd_valid, rd_byte, done
    );

    modport eng (
        input  start, opcode, addr, has_addr, wr_len, rd_len,
        output wr_pop, rd_valid, rd_byte, done
    );

endinterface

/* src/flash_cmd_port.sv */
// ----------------------------------------------------------
// host side of the controller, four-phase req/ack handshake
// latches the job and holds ack until the host lets go of req
// ----------------------------------------------------------
module flash_cmd_port (
    input  logic              clk,
    input  logic              rst,
    input  logic              job_req,
    input  flash_pkg::job_t   job_type,
    input  flash_pkg::len_t   job_bytes,
    output logic              job_ack,
    flash_job_if.cmd_port     job
);

    typedef enum logic [1:0] {
        ph_wait_req,
        ph_busy,
        ph_ack_high,
        ph_release
    } phase_t;

    phase_t phase;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= ph_wait_req;
            job_ack   <= 1'b0;
            job.start <= 1'b0;
        end else begin
            job.start <= 1'b0;
            case (phase)
                ph_wait_req: begin
                    if (job_req) begin
                        job.kind  <= job_type;
                        job.bytes <= job_bytes;
                        job.start <= 1'b1;
                        phase     <= ph_busy;
                    end
                end
                ph_busy: begin
                    // completion is what raises ack
                    if (job.done) begin
                        job_ack <= 1'b1;
                        phase   <= ph_ack_high;
                    end
                end
                ph_ack_high: begin
                    if (!job_req) begin
                        job_ack <= 1'b0;
                        phase   <= ph_release;
                    end
                end
                // req and ack both low here, next job may follow
                default: phase <= ph_wait_req;
            endcase
        end
    end

endmodule

/* src/flash_sequencer.sv */
// ----------------------------------------------------------
// job sequencer: status polling, write enable, sector erase,
// page program and read, issued as SPI transactions one at a time
// ----------------------------------------------------------
module flash_sequencer (
    input  logic               clk,
    input  logic               rst,
    flash_job_if.seq           job,
    spi_cmd_if.seq             spi,
    output flash_pkg::byte_t   rd_data,
    output logic               rd_data_valid
);

    flash_pkg::seq_state_t  state;
    flash_pkg::len_t        bytes_left;
    flash_pkg::flash_addr_t cur_addr;
    flash_pkg::byte_t       status;
    flash_pkg::xfer_len_t   page_len;
    flash_pkg::xfer_len_t   read_len;

    logic                   cmd_start;
    flash_pkg::opcode_t     cmd_op;
    flash_pkg::flash_addr_t cmd_addr;
    logic                   cmd_has_addr;
    flash_pkg::xfer_len_t   cmd_wr_len;
    flash_pkg::xfer_len_t   cmd_rd_len;

    // queue one transaction for the engine
    task automatic send(input flash_pkg::opcode_t op, input logic with_addr,
                        input flash_pkg::xfer_len_t wlen,
                        input flash_pkg::xfer_len_t rlen);
        cmd_start    <= 1'b1;
        cmd_op       <= op;
        cmd_addr     <= cur_addr;
        cmd_has_addr <= with_addr;
        cmd_wr_len   <= wlen;
        cmd_rd_len   <= rlen;
    endtask

    // last page may be short
    assign page_len = (bytes_left > flash_pkg::page_bytes) ?
                      flash_pkg::xfer_len_t'(flash_pkg::page_bytes) :
                      flash_pkg::xfer_len_t'(bytes_left);
    assign read_len = (bytes_left > flash_pkg::len_t'(9'h1FF)) ?
                      9'h1FF : flash_pkg::xfer_len_t'(bytes_left);

    assign spi.start    = cmd_start;
    assign spi.opcode   = cmd_op;
    assign spi.addr     = cmd_addr;
    assign spi.has_addr = cmd_has_addr;
    assign spi.wr_len   = cmd_wr_len;
    assign spi.rd_len   = cmd_rd_len;

    assign job.done      = (state == flash_pkg::st_done);
    assign rd_data       = spi.rd_byte;
    assign rd_data_valid = spi.rd_valid && (state == flash_pkg::st_read);

    // last status byte, checked when the rdsr transaction ends
    always_ff @(posedge clk) begin
        if (spi.rd_valid) begin
            status <= spi.rd_byte;
        end
    end

    // ----------------------------------------------------------
    // job FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= flash_pkg::st_idle;
            cmd_start <= 1'b0;
        end else begin
            cmd_start <= 1'b0;
            case (state)
                flash_pkg::st_idle: begin
                    if (job.start) begin
                        bytes_left <= job.bytes;
                        cur_addr   <= '0;
                        if (job.bytes == '0) begin
                            state <= flash_pkg::st_done;
                        end else begin
                            send(flash_pkg::op_rdsr, 1'b0, '0, 9'd1);
                            state <= flash_pkg::st_poll_ready;
                        end
                    end
                end
                flash_pkg::st_poll_ready: begin
                    if (spi.done) begin
                        if (status[flash_pkg::sr_wip_bit]) begin
                            send(flash_pkg::op_rdsr, 1'b0, '0, 9'd1);
                        end else if (job.kind == flash_pkg::job_read) begin
                            send(flash_pkg::op_read, 1'b1, '0, read_len);
                            state <= flash_pkg::st_read;
                        end else begin
                            send(flash_pkg::op_wren, 1'b0, '0, '0);
                            state <= flash_pkg::st_wren;
                        end
                    end
                end
                flash_pkg::st_wren: begin
                    if (spi.done) begin
                        send(flash_pkg::op_rdsr, 1'b0, '0, 9'd1);
                        state <= flash_pkg::st_wel_check;
                    end
                end
                flash_pkg::st_wel_check: begin
                    if (spi.done) begin
                        if (!status[flash_pkg::sr_wel_bit]) begin
                            send(flash_pkg::op_rdsr, 1'b0, '0, 9'd1);
                        end else if (job.kind == flash_pkg::job_erase) begin
                            send(flash_pkg::op_sector_erase, 1'b1, '0, '0);
                            state <= flash_pkg::st_erase;
                        end else begin
                            send(flash_pkg::op_page_program, 1'b1, page_len, '0);
                            state <= flash_pkg::st_program;
                        end
                    end
                end
                flash_pkg::st_erase: begin
                    if (spi.done) begin
                        cur_addr <= cur_addr + flash_pkg::flash_addr_t'(flash_pkg::sector_bytes);
                        if (bytes_left <= flash_pkg::sector_bytes) begin
                            bytes_left <= '0;
                            state      <= flash_pkg::st_done;
                        end else begin
                            bytes_left <= bytes_left - flash_pkg::sector_bytes;
                            send(flash_pkg::op_rdsr, 1'b0, '0, 9'd1);
                            state <= flash_pkg::st_poll_ready;
                        end
                    end
                end
                flash_pkg::st_program: begin
                    if (spi.done) begin
                        cur_addr   <= cur_addr + flash_pkg::flash_addr_t'(cmd_wr_len);
                        bytes_left <= bytes_left - flash_pkg::len_t'(cmd_wr_len);
                        if (bytes_left == flash_pkg::len_t'(cmd_wr_len)) begin
                            state <= flash_pkg::st_done;
                        end else begin
                            send(flash_pkg::op_rdsr, 1'b0, '0, 9'd1);
                            state <= flash_pkg::st_poll_ready;
                        end
                    end
                end
                flash_pkg::st_read: begin
                    if (spi.done) begin
                        state <= flash_pkg::st_done;
                    end
                end
                default: state <= flash_pkg::st_idle;
            endcase
        end
    end

endmodule

/* src/spi_engine.sv */
// ----------------------------------------------------------
// SPI mode-0 shifter, MSB first: opcode, optional 24-bit address,
// write bytes then read bytes in one chip-select frame
// ----------------------------------------------------------
module spi_engine #(
    parameter int spi_clk_div = 2
) (
    input  logic               clk,
    input  logic               rst,
    spi_cmd_if.eng             spi,
    input  flash_pkg::byte_t   wr_data,
    input  logic               spi_miso,
    output logic               spi_clk,
    output logic               spi_cs_n,
    output logic               spi_mosi
);

    localparam int div_w = (spi_clk_div > 1) ? $clog2(spi_clk_div) : 1;
    localparam logic [div_w-1:0] div_last = div_w'(spi_clk_div - 1);

    logic              busy;
    logic              closing;
    logic              half_end;
    logic [div_w-1:0]  div_cnt;
    logic [2:0]        bit_cnt;
    // frame byte index: opcode, address, write, read
    logic [10:0]       byte_cnt;
    logic [10:0]       nxt_idx;
    logic [10:0]       hdr_len;
    logic [10:0]       wr_end;
    logic [10:0]       frame_len;
    logic              nxt_is_wr;
    flash_pkg::byte_t  nxt_byte;
    flash_pkg::byte_t  sh_out;
    flash_pkg::byte_t  sh_in;

    assign hdr_len   = spi.has_addr ? 11'd4 : 11'd1;
    assign wr_end    = hdr_len + 11'(spi.wr_len);
    assign frame_len = wr_end + 11'(spi.rd_len);
    assign nxt_idx   = byte_cnt + 11'd1;
    assign nxt_is_wr = (nxt_idx >= hdr_len) && (nxt_idx < wr_end);
    assign half_end  = busy && (div_cnt == div_last);

    assign spi_mosi    = sh_out[7];
    assign spi.rd_byte = sh_in;

    // byte to shift out after the current one
    always_comb begin
        nxt_byte = 8'h00;
        if (nxt_idx < hdr_len) begin
            case (nxt_idx[1:0])
                2'd1:    nxt_byte = spi.addr[23:16];
                2'd2:    nxt_byte = spi.addr[15:8];
                default: nxt_byte = spi.addr[7:0];
            endcase
        end else if (nxt_is_wr) begin
            nxt_byte = wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy         <= 1'b0;
            closing      <= 1'b0;
            spi_cs_n     <= 1'b1;
            spi_clk      <= 1'b0;
            spi.done     <= 1'b0;
            spi.rd_valid <= 1'b0;
            spi.wr_pop   <= 1'b0;
        end else begin
            closing      <= 1'b0;
            spi.done     <= closing;
            spi.rd_valid <= 1'b0;
            spi.wr_pop   <= 1'b0;
            if (spi.start && !busy) begin
                busy     <= 1'b1;
                spi_cs_n <= 1'b0;
                div_cnt  <= '0;
                bit_cnt  <= '0;
                byte_cnt <= '0;
                sh_out   <= spi.opcode;
            end else if (busy) begin
                div_cnt <= half_end ? '0 : div_cnt + 1'b1;
                if (half_end && !spi_clk) begin
                    // rising edge, sample miso
                    spi_clk <= 1'b1;
                    sh_in   <= {sh_in[6:0], spi_miso};
                end else if (half_end) begin
                    spi_clk <= 1'b0;
                    if (bit_cnt != 3'd7) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        sh_out  <= {sh_out[6:0], 1'b0};
                    end else begin
                        spi.rd_valid <= (byte_cnt >= wr_end);
                        if (nxt_idx == frame_len) begin
                            busy     <= 1'b0;
                            spi_cs_n <= 1'b1;
                            closing  <= 1'b1;
                        end else begin
                            bit_cnt    <= '0;
                            byte_cnt   <= nxt_idx;
                            sh_out     <= nxt_byte;
                            spi.wr_pop <= nxt_is_wr;
                        end
                    end
                end
            end
        end
    end

endmodule

/* src/flash_ctrl.sv */
// ----------------------------------------------------------
// SPI NOR flash controller top for multi-boot images
// host job port on one side, SPI flash pins on the other
// ----------------------------------------------------------
module flash_ctrl #(
    parameter int spi_clk_div = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               job_req,
    input  flash_pkg::job_t    job_type,
    input  flash_pkg::len_t    job_bytes,
    output logic               job_ack,
    input  flash_pkg::byte_t   wr_data,
    output logic               wr_data_pop,
    output flash_pkg::byte_t   rd_data,
    output logic               rd_data_valid,
    output logic               spi_clk,
    output logic               spi_cs_n,
    output logic               spi_mosi,
    input  logic               spi_miso
);

    flash_job_if job_bus ();
    spi_cmd_if   spi_bus ();

    assign wr_data_pop = spi_bus.wr_pop;

    flash_cmd_port u_cmd_port (
        .clk       (clk),
        .rst       (rst),
        .job_req   (job_req),
        .job_type  (job_type),
        .job_bytes (job_bytes),
        .job_ack   (job_ack),
        .job       (job_bus.cmd_port)
    );

    flash_sequencer u_sequencer (
        .clk           (clk),
        .rst           (rst),
        .job           (job_bus.seq),
        .spi           (spi_bus.seq),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid)
    );

    spi_engine #(
        .spi_clk_div (spi_clk_div)
    ) u_spi_engine (
        .clk      (clk),
        .rst      (rst),
        .spi      (spi_bus.eng),
        .wr_data  (wr_data),
        .spi_miso (spi_miso),
        .spi_clk  (spi_clk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi)
    );

endmodule

/* bench/flash_model.sv */
// ----------------------------------------------------------
// behavioural SPI NOR flash for the testbench, mode 0, 16 KB
// status register with WIP and WEL, sector erase, page program
// ----------------------------------------------------------
module flash_model (
    input  logic spi_clk,
    input  logic spi_cs_n,
    input  logic spi_mosi,
    output logic spi_miso
);

    flash_pkg::byte_t   mem [0:16383];
    flash_pkg::byte_t   in_sh;
    flash_pkg::byte_t   out_sh;
    flash_pkg::opcode_t op;
    logic [23:0]        addr;
    logic               wel;
    // WEL as seen when the opcode arrived
    logic               armed;
    logic               last_clk;
    logic               last_cs;
    int                 bit_cnt;
    int                 busy_reads;

    // one complete byte from the host, idx counts from the opcode
    task automatic take_byte(input int idx);
        if (idx == 0) begin
            op    = in_sh;
            armed = wel;
            if (op == flash_pkg::op_rdsr) begin
                out_sh = {6'b000000, wel, busy_reads != 0};
                if (busy_reads > 0) begin
                    busy_reads = busy_reads - 1;
                end
            end
        end else if (idx < 4) begin
            addr = {addr[15:0], in_sh};
        end else if (op == flash_pkg::op_page_program && armed) begin
            mem[addr[13:0]] = in_sh;
            addr = addr + 24'd1;
        end
        // read data follows the address without a dummy byte
        if (op == flash_pkg::op_read && idx >= 3) begin
            out_sh = mem[addr[13:0]];
            addr   = addr + 24'd1;
        end
    endtask

    // erase and program take effect when chip select rises
    task automatic end_frame();
        if (op == flash_pkg::op_wren && bit_cnt == 8) begin
            wel = 1'b1;
        end else if (armed && bit_cnt >= 32 && op == flash_pkg::op_sector_erase) begin
            for (int i = 0; i < 4096; i++) begin
                mem[{addr[13:12], 12'h000} + i] = 8'hFF;
            end
            wel        = 1'b0;
            busy_reads = 3;
        end else if (armed && bit_cnt >= 32 && op == flash_pkg::op_page_program) begin
            wel        = 1'b0;
            busy_reads = 3;
        end
    endtask

    initial begin
        for (int i = 0; i < 16384; i++) begin
            mem[i] = 8'h00;
        end
        wel        = 1'b0;
        armed      = 1'b0;
        busy_reads = 0;
        bit_cnt    = 0;
        out_sh     = 8'h00;
        spi_miso   = 1'b0;
        last_clk   = spi_clk;
        last_cs    = spi_cs_n;
        forever begin
            @(spi_clk or spi_cs_n);
            if (spi_cs_n !== last_cs) begin
                if (spi_cs_n === 1'b0) begin
                    bit_cnt = 0;
                    out_sh  = 8'h00;
                end else begin
                    end_frame();
                end
            end else if (spi_clk !== last_clk && spi_cs_n === 1'b0) begin
                if (spi_clk === 1'b1) begin
                    in_sh   = {in_sh[6:0], spi_mosi};
                    bit_cnt = bit_cnt + 1;
                    if (bit_cnt % 8 == 0) begin
                        take_byte(bit_cnt / 8 - 1);
                    end
                end else begin
                    // miso changes while spi_clk is low
                    spi_miso = out_sh[7];
                    out_sh   = {out_sh[6:0], 1'b0};
                end
            end
            last_clk = spi_clk;
            last_cs  = spi_cs_n;
        end
    end

endmodule

/* bench/tb_flash_ctrl.sv */
// ----------------------------------------------------------
// directed testbench for the flash controller against a flash model
// program, erase, read back and the req/ack handshake
// ----------------------------------------------------------
module tb_flash_ctrl;

    localparam int spi_clk_div = 2;
    // job byte counts of all tests size the watchdog
    localparam int total_job_bytes = 300 + 256 + 44 + 1 + 256 + 4097 + 32 + 48;
    localparam int byte_time = 16 * spi_clk_div * 4;

    logic             clk;
    logic             rst;
    logic             job_req;
    flash_pkg::job_t  job_type;
    flash_pkg::len_t  job_bytes;
    logic             job_ack;
    flash_pkg::byte_t wr_data;
    logic             wr_data_pop;
    flash_pkg::byte_t rd_data;
    logic             rd_data_valid;
    logic             spi_clk;
    logic             spi_cs_n;
    logic             spi_mosi;
    logic             spi_miso;

    flash_pkg::byte_t wr_buf [0:511];
    flash_pkg::byte_t rd_buf [0:1023];
    flash_pkg::byte_t exp_buf [0:255];
    int               pop_count;
    int               rd_count;

    flash_ctrl #(
        .spi_clk_div (spi_clk_div)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .job_req       (job_req),
        .job_type      (job_type),
        .job_bytes     (job_bytes),
        .job_ack       (job_ack),
        .wr_data       (wr_data),
        .wr_data_pop   (wr_data_pop),
        .rd_data       (rd_data),
        .rd_data_valid (rd_data_valid),
        .spi_clk       (spi_clk),
        .spi_cs_n      (spi_cs_n),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso)
    );

    flash_model u_flash (
        .spi_clk  (spi_clk),
        .spi_cs_n (spi_cs_n),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // ----------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------
    task automatic check_byte(input string name, input flash_pkg::byte_t exp,
                              input flash_pkg::byte_t got);
        if (got !== exp) begin
            $display("Error %s exp %h got %h", name, exp, got);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input flash_pkg::len_t exp,
                               input flash_pkg::len_t got);
        if (got !== exp) begin
            $display("Error %s exp %h got %h", name, exp, got);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Error %s exp %h got %h", name, exp, got);
            $display("SIMULATION FAILED");
            $fatal(1);
        end
    endtask

    // ----------------------------------------------------------
    // host side processes
    // ----------------------------------------------------------
    // next program byte is presented one unit after each pop
    initial begin : write_source
        logic [31:0] seed;
        seed = 32'd57597;
        for (int i = 0; i < 512; i++) begin
            seed      = xorshift32(seed);
            wr_buf[i] = seed[7:0];
        end
        pop_count = 0;
        wr_data   = wr_buf[0];
        forever begin
            @(posedge clk);
            if (wr_data_pop) begin
                pop_count = pop_count + 1;
                #1 wr_data = wr_buf[pop_count % 512];
            end
        end
    end

    initial begin : read_sink
        rd_count = 0;
        forever begin
            @(posedge clk);
            if (rd_data_valid) begin
                rd_buf[rd_count % 1024] = rd_data;
                rd_count = rd_count + 1;
            end
        end
    end

    initial begin : watchdog
        #(total_job_bytes * byte_time + 200000);
        $display("watchdog expired, a job never completed");
        $display("SIMULATION FAILED");
        $fatal(1);
    end

    // one four-phase job with req held for hold extra cycles after ack
    task automatic run_job(input flash_pkg::job_t kind, input flash_pkg::len_t nbytes,
                           input int hold);
        job_type  = kind;
        job_bytes = nbytes;
        job_req   = 1'b1;
        do begin
            @(posedge clk);
        end while (!job_ack);
        #1;
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_bit("job_ack", 1'b1, job_ack);
        end
        job_req = 1'b0;
        @(posedge clk);
        #1;
        check_bit("job_ack", 1'b0, job_ack);
    endtask

    task automatic read_and_compare(input flash_pkg::len_t nbytes, input int hold);
        int base;
        base = rd_count;
        run_job(flash_pkg::job_read, nbytes, hold);
        check_count("rd_data_valid count", nbytes, flash_pkg::len_t'(rd_count - base));
        for (int i = 0; i < nbytes; i++) begin
            check_byte("rd_data", exp_buf[i], rd_buf[(base + i) % 1024]);
        end
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------
    task automatic program_and_read_back();
        run_job(flash_pkg::job_program, 32'd300, 0);
        check_count("wr_data_pop count", 32'd300, flash_pkg::len_t'(pop_count));
        // second page lies past the boundary
        for (int i = 256; i < 300; i++) begin
            check_byte("u_flash.mem", wr_buf[i], u_flash.mem[i]);
        end
        for (int i = 0; i < 256; i++) begin
            exp_buf[i] = wr_buf[i];
        end
        read_and_compare(32'd256, 0);
        read_and_compare(32'd44, 0);
    endtask

    task automatic erase_one_sector();
        u_flash.mem[4096] = 8'h5A;
        run_job(flash_pkg::job_erase, 32'd1, 0);
        for (int i = 0; i < 256; i++) begin
            exp_buf[i] = 8'hFF;
        end
        read_and_compare(32'd256, 0);
        check_byte("u_flash.mem", 8'h5A, u_flash.mem[4096]);
    endtask

    task automatic erase_rounded_up();
        u_flash.mem[8192] = 8'h3C;
        run_job(flash_pkg::job_erase, 32'd4097, 0);
        for (int i = 4096; i < 8192; i++) begin
            check_byte("u_flash.mem", 8'hFF, u_flash.mem[i]);
        end
        check_byte("u_flash.mem", 8'h3C, u_flash.mem[8192]);
    endtask

    task automatic handshake_hold();
        for (int i = 0; i < 256; i++) begin
            u_flash.mem[i] = flash_pkg::byte_t'(i * 37 + 11);
            exp_buf[i]     = flash_pkg::byte_t'(i * 37 + 11);
        end
        read_and_compare(32'd32, 10);
        read_and_compare(32'd48, 0);
    endtask

    initial begin : main
        rst       = 1'b1;
        job_req   = 1'b0;
        job_type  = flash_pkg::job_read;
        job_bytes = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        check_bit("job_ack", 1'b0, job_ack);
        check_bit("wr_data_pop", 1'b0, wr_data_pop);
        check_bit("rd_data_valid", 1'b0, rd_data_valid);
        check_bit("spi_cs_n", 1'b1, spi_cs_n);
        check_bit("spi_clk", 1'b0, spi_clk);
        program_and_read_back();
        erase_one_sector();
        erase_rounded_up();
        handshake_hold();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* files.f */
src/flash_pkg.sv
src/flash_job_if.sv
src/spi_cmd_if.sv
src/flash_cmd_port.sv
src/flash_sequencer.sv
src/spi_engine.sv
src/flash_ctrl.sv
bench/flash_model.sv
bench/tb_flash_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the flash controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module tb_flash_ctrl -Mdir obj_dir
./obj_dir/Vtb_flash_ctrl > sim.log 2>&1 || true
cat sim.log
if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
